//--- rtl/fb_bridge_pkg.sv
package fb_bridge_pkg;

	// --------------------------------------------------
	// Data types
	// --------------------------------------------------
	typedef logic [31:0] word_t;      // Wishbone and frame buffer word
	typedef logic [7:0]  pixel_t;     // One camera byte
	typedef logic [3:0]  nibble_t;    // QSPI lanes 3:0
	typedef logic [23:0] qspi_addr_t; // SRAM byte address

	// --------------------------------------------------
	// QSPI SRAM frame format
	// --------------------------------------------------
	localparam logic [7:0] QSPI_CMD_WRITE = 8'h38; // Quad write, sent serially on lane 0

	localparam int CMD_BITS     = 8; // Command cycles, one bit each
	localparam int ADDR_NIBBLES = 6; // 24-bit address, MS nibble first
	localparam int WORD_NIBBLES = 8; // Data cycles per 32-bit word

	// --------------------------------------------------
	// Register map
	// --------------------------------------------------
	localparam logic [1:0] MODE_FLUSH = 2'b10; // Ctrl bits 1:0, drain banks to SRAM

	localparam logic REG_CTRL   = 1'b0; // Host control word
	localparam logic REG_STATUS = 1'b1; // Read-only status

	// Status word layout, all other bits read zero
	localparam int STAT_BANK_BIT  = 0; // Bank the camera is filling
	localparam int STAT_BUSY_BIT  = 4; // Burst writer active
	localparam int STAT_VSYNC_BIT = 8; // Live VSYNC level

endpackage

//--- rtl/wb_ctrl_regs.sv
`timescale 1ns/1ps

module wb_ctrl_regs (
	input  logic                 WBs_CLK_i,    // Bus clock
	input  logic                 WBs_RST_i,    // Async reset, active high
	input  logic                 wbs_cyc_i,    // Bus cycle
	input  logic                 wbs_stb_i,    // Transfer strobe
	input  logic                 wbs_we_i,     // Write enable
	input  logic                 wbs_adr_i,    // Register select
	input  fb_bridge_pkg::word_t wbs_dat_i,    // Write data
	input  logic                 cam_vsync_i,  // Camera frame level
	input  logic                 cam_bank_i,   // Bank being filled
	input  logic                 flush_busy_i, // Writer not idle
	output logic                 wbs_ack_o,    // One-cycle acknowledge
	output fb_bridge_pkg::word_t wbs_dat_o,    // Read data, valid with ack
	output logic                 flush_mode_o  // Mode field equals flush
);

	import fb_bridge_pkg::*;

	logic  acc_go;   // Access pending, ack on next edge
	logic  wr_go;    // Control register write
	word_t ctrl_q;   // Host-written control word
	word_t status_w; // Assembled status

	// Ack blocks a second decode while it is high
	assign acc_go = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
	assign wr_go  = acc_go & wbs_we_i & (wbs_adr_i == REG_CTRL);

	// --------------------------------------------------
	// Acknowledge and control register
	// --------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wbs_ack_o <= 1'b0;
			ctrl_q    <= '0;
		end else begin
			wbs_ack_o <= acc_go; // Held strobe gives ack every 2nd cycle
			if (wr_go) begin
				ctrl_q <= wbs_dat_i; // Lands on the same edge as ack
			end
		end
	end

	// --------------------------------------------------
	// Status word and read data
	// --------------------------------------------------
	always_comb begin
		status_w                 = '0;
		status_w[STAT_BANK_BIT]  = cam_bank_i;
		status_w[STAT_BUSY_BIT]  = flush_busy_i;
		status_w[STAT_VSYNC_BIT] = cam_vsync_i;
	end

	// Captured with the ack so it is stable for the whole ack cycle
	always_ff @(posedge WBs_CLK_i) begin
		if (acc_go) begin
			case (wbs_adr_i)
				REG_CTRL:   wbs_dat_o <= ctrl_q;
				REG_STATUS: wbs_dat_o <= status_w;
			endcase
		end
	end

	assign flush_mode_o = (ctrl_q[1:0] == MODE_FLUSH); // Level, no edge detect

endmodule

//--- rtl/cam_word_packer.sv
`timescale 1ns/1ps

module cam_word_packer #(
	parameter int BANK_WORDS = 512 // Words per bank, power of two
) (
	input  logic                          WBs_CLK_i,   // System clock
	input  logic                          WBs_RST_i,   // Async reset, active high
	input  logic                          cam_vsync_i, // Frame valid level
	input  logic                          cam_href_i,  // Line valid level
	input  fb_bridge_pkg::pixel_t         cam_dat_i,   // Camera byte
	output logic                          wr_en_o,     // One-cycle word write
	output logic [$clog2(BANK_WORDS):0]   wr_addr_o,   // Bank bit plus word index
	output fb_bridge_pkg::word_t          wr_data_o,   // Packed word
	output logic                          cam_bank_o   // Bank being filled
);

	import fb_bridge_pkg::*;

	localparam int AW = $clog2(BANK_WORDS) + 1; // Spans both banks

	logic          byte_ok;  // Byte taken this edge
	logic [1:0]    byte_cnt; // Bytes held in the current word
	pixel_t [2:0]  shift_q;  // First three bytes, oldest in [2]
	logic [AW-1:0] word_cnt; // Write position over both banks

	assign byte_ok = cam_vsync_i & cam_href_i;

	// --------------------------------------------------
	// Byte count, write strobe and word counter
	// --------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			byte_cnt <= 2'd0;
			wr_en_o  <= 1'b0;
			word_cnt <= '0;
		end else begin
			wr_en_o <= byte_ok && (byte_cnt == 2'd3); // Fourth byte completes the word
			if (byte_ok) begin
				byte_cnt <= byte_cnt + 2'd1; // Wraps to 0 after the fourth
			end
			if (wr_en_o) begin
				word_cnt <= word_cnt + 1'b1; // Wraps at 2 x BANK_WORDS
			end
		end
	end

	// Partial word simply waits across HREF or VSYNC gaps
	always_ff @(posedge WBs_CLK_i) begin
		if (byte_ok) begin
			if (byte_cnt == 2'd3) begin
				wr_data_o <= {shift_q, cam_dat_i}; // First byte lands in 31:24
			end else begin
				shift_q <= {shift_q[1:0], cam_dat_i};
			end
		end
	end

	assign wr_addr_o  = word_cnt;
	assign cam_bank_o = word_cnt[AW-1]; // Top bit picks the bank

endmodule

//--- rtl/fb_pingpong_ram.sv
`timescale 1ns/1ps

module fb_pingpong_ram #(
	parameter int BANK_WORDS = 512 // Words per bank, power of two
) (
	input  logic                        WBs_CLK_i, // System clock
	input  logic                        wr_en_i,   // Word write strobe
	input  logic [$clog2(BANK_WORDS):0] wr_addr_i, // Bank bit plus word index
	input  fb_bridge_pkg::word_t        wr_data_i, // Packed camera word
	input  logic [$clog2(BANK_WORDS):0] rd_addr_i, // Writer read address
	output fb_bridge_pkg::word_t        rd_data_o  // One cycle after rd_addr_i
);

	import fb_bridge_pkg::*;

	localparam int DEPTH = 2 * BANK_WORDS; // Bank 0 low half, bank 1 high half

	word_t mem_q [DEPTH]; // Frame buffer storage

	// --------------------------------------------------
	// Camera write port
	// --------------------------------------------------
	always_ff @(posedge WBs_CLK_i) begin
		if (wr_en_i) begin
			mem_q[wr_addr_i] <= wr_data_i;
		end
	end

	// --------------------------------------------------
	// Writer read port
	// --------------------------------------------------
	// Same-cycle write and read of one address returns the old word
	always_ff @(posedge WBs_CLK_i) begin
		rd_data_o <= mem_q[rd_addr_i];
	end

endmodule

//--- rtl/qspi_burst_writer.sv
`timescale 1ns/1ps

module qspi_burst_writer #(
	parameter int                        BANK_WORDS  = 512,      // Words per bank
	parameter int                        BURST_WORDS = 128,      // Words per QSPI burst
	parameter fb_bridge_pkg::qspi_addr_t START_ADDR  = 24'h000004 // First SRAM address
) (
	input  logic                        WBs_CLK_i,    // System clock
	input  logic                        WBs_RST_i,    // Async reset, active high
	input  logic                        flush_mode_i, // Draining allowed
	input  logic                        cam_bank_i,   // Bank the camera is filling
	input  fb_bridge_pkg::word_t        rd_data_i,    // Frame buffer read data
	output logic [$clog2(BANK_WORDS):0] rd_addr_o,    // Frame buffer read address
	output logic                        flush_busy_o, // Not idle
	output logic                        qspi_ncs_o,   // Chip select, active low
	output fb_bridge_pkg::nibble_t      qspi_dat_o    // Lanes 3:0
);

	import fb_bridge_pkg::*;

	localparam int IW     = $clog2(BANK_WORDS);                             // Word index in bank
	localparam int WSH    = $clog2(BURST_WORDS);                            // Burst index shift
	localparam int WCW    = (BURST_WORDS > 1) ? WSH : 1;                    // Word counter width
	localparam int BURSTS = BANK_WORDS / BURST_WORDS;                       // Bursts per bank
	localparam int BCW    = (BURSTS > 1) ? $clog2(BURSTS) : 1;              // Burst counter width
	localparam qspi_addr_t BURST_STEP = qspi_addr_t'(BURST_WORDS * 4);      // Bytes per burst

	typedef enum logic [2:0] {
		ST_IDLE, // Also waits for the next bank
		ST_CMD,
		ST_ADDR,
		ST_DATA,
		ST_GAP
	} state_t;

	state_t         state;
	logic [2:0]     sym_cnt;    // Symbol within phase, also gap length
	logic [WCW-1:0] word_cnt;   // Word within burst
	logic [BCW-1:0] burst_cnt;  // Burst within bank
	logic           flush_bank; // Bank to drain next
	qspi_addr_t     burst_addr; // SRAM address of the next burst
	logic [7:0]     cmd_sr;     // Command, MSB out first
	qspi_addr_t     addr_sr;    // Address, MS nibble out first
	word_t          data_sr;    // Current word, MS nibble out first
	logic [WCW-1:0] rd_word;    // Word index the RAM is asked for

	logic bank_ready;  // Handoff rule
	logic gap_done;
	logic last_burst;
	logic start_burst; // Load shifters, enter command phase
	logic cmd_last;
	logic addr_last;
	logic nib_last;    // Last nibble of a word
	logic word_last;   // Last nibble of the burst

	// --------------------------------------------------
	// Phase decode
	// --------------------------------------------------
	assign bank_ready  = flush_mode_i && (cam_bank_i != flush_bank); // Camera has left it
	assign gap_done    = (state == ST_GAP) && (sym_cnt == 3'd1);     // Two cycles high
	assign last_burst  = (burst_cnt == BCW'(BURSTS - 1));
	assign start_burst = ((state == ST_IDLE) && bank_ready) || (gap_done && !last_burst);
	assign cmd_last    = (state == ST_CMD) && (sym_cnt == 3'(CMD_BITS - 1));
	assign addr_last   = (state == ST_ADDR) && (sym_cnt == 3'(ADDR_NIBBLES - 1));
	assign nib_last    = (state == ST_DATA) && (sym_cnt == 3'(WORD_NIBBLES - 1));
	assign word_last   = nib_last && (word_cnt == WCW'(BURST_WORDS - 1));

	// --------------------------------------------------
	// Control FSM and counters
	// --------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			state      <= ST_IDLE;
			sym_cnt    <= 3'd0;
			word_cnt   <= '0;
			burst_cnt  <= '0;
			flush_bank <= 1'b0;
			burst_addr <= START_ADDR;
		end else begin
			case (state)
				ST_IDLE: begin
					if (bank_ready) begin
						state   <= ST_CMD;
						sym_cnt <= 3'd0;
					end
				end
				ST_CMD: begin
					if (cmd_last) begin
						state   <= ST_ADDR;
						sym_cnt <= 3'd0;
					end else begin
						sym_cnt <= sym_cnt + 3'd1;
					end
				end
				ST_ADDR: begin
					if (addr_last) begin
						state   <= ST_DATA; // First word already prefetched
						sym_cnt <= 3'd0;
					end else begin
						sym_cnt <= sym_cnt + 3'd1;
					end
				end
				ST_DATA: begin
					if (nib_last) begin
						sym_cnt  <= 3'd0;
						word_cnt <= word_last ? '0 : word_cnt + 1'b1;
						if (word_last) begin
							state      <= ST_GAP;
							burst_addr <= burst_addr + BURST_STEP; // 24-bit wrap
						end
					end else begin
						sym_cnt <= sym_cnt + 3'd1;
					end
				end
				ST_GAP: begin
					if (gap_done) begin
						sym_cnt <= 3'd0;
						if (last_burst) begin
							state      <= ST_IDLE; // Bank done, wait for the other one
							burst_cnt  <= '0;
							flush_bank <= ~flush_bank;
						end else begin
							state     <= ST_CMD;
							burst_cnt <= burst_cnt + 1'b1;
						end
					end else begin
						sym_cnt <= sym_cnt + 3'd1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// Shift registers
	// --------------------------------------------------
	always_ff @(posedge WBs_CLK_i) begin
		if (start_burst) begin
			cmd_sr  <= QSPI_CMD_WRITE;
			addr_sr <= burst_addr;
		end
		if (state == ST_CMD) begin
			cmd_sr <= {cmd_sr[6:0], 1'b0};
		end
		if (state == ST_ADDR) begin
			addr_sr <= {addr_sr[19:0], 4'h0};
		end
		if (addr_last || nib_last) begin
			data_sr <= rd_data_i; // Gapless handoff to the next word
		end else if (state == ST_DATA) begin
			data_sr <= {data_sr[27:0], 4'h0};
		end
	end

	// During data, ask for the following word so it is ready at nib_last
	assign rd_word   = word_cnt + WCW'(state == ST_DATA);
	assign rd_addr_o = {flush_bank, (IW'(burst_cnt) << WSH) | IW'(rd_word)};

	// --------------------------------------------------
	// Pins
	// --------------------------------------------------
	always_comb begin
		case (state)
			ST_CMD:  qspi_dat_o = {3'b000, cmd_sr[7]}; // Command on lane 0 only
			ST_ADDR: qspi_dat_o = addr_sr[23:20];
			ST_DATA: qspi_dat_o = data_sr[31:28];
			default: qspi_dat_o = 4'h0; // Quiet while deselected
		endcase
	end

	assign qspi_ncs_o   = !((state == ST_CMD) || (state == ST_ADDR) || (state == ST_DATA));
	assign flush_busy_o = (state != ST_IDLE);

endmodule

//--- rtl/cam_qspi_bridge_top.sv
`timescale 1ns/1ps

module cam_qspi_bridge_top #(
	parameter int                        BANK_WORDS  = 512,       // Words per bank
	parameter int                        BURST_WORDS = 128,       // Words per QSPI burst
	parameter fb_bridge_pkg::qspi_addr_t START_ADDR  = 24'h000004 // First SRAM address
) (
	input  logic                   WBs_CLK_i,   // Single system clock
	input  logic                   WBs_RST_i,   // Async reset, active high
	input  logic                   wbs_cyc_i,
	input  logic                   wbs_stb_i,
	input  logic                   wbs_we_i,
	input  logic                   wbs_adr_i,   // Ctrl or status
	input  fb_bridge_pkg::word_t   wbs_dat_i,
	input  logic                   cam_vsync_i, // Synchronous to WBs_CLK_i
	input  logic                   cam_href_i,
	input  fb_bridge_pkg::pixel_t  cam_dat_i,
	output logic                   wbs_ack_o,
	output fb_bridge_pkg::word_t   wbs_dat_o,
	output logic                   qspi_ncs_o,  // SRAM select, active low
	output fb_bridge_pkg::nibble_t qspi_dat_o   // SRAM lanes
);

	import fb_bridge_pkg::*;

	localparam int AW = $clog2(BANK_WORDS) + 1; // Frame buffer address width

	logic          wr_en;      // Packer to RAM
	logic [AW-1:0] wr_addr;
	word_t         wr_data;
	logic [AW-1:0] rd_addr;    // Writer to RAM
	word_t         rd_data;
	logic          cam_bank;   // Packer to writer and status
	logic          flush_mode; // Ctrl register to writer
	logic          flush_busy; // Writer to status

	// --------------------------------------------------
	// Host registers
	// --------------------------------------------------
	wb_ctrl_regs i_regs (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.wbs_cyc_i    (wbs_cyc_i),
		.wbs_stb_i    (wbs_stb_i),
		.wbs_we_i     (wbs_we_i),
		.wbs_adr_i    (wbs_adr_i),
		.wbs_dat_i    (wbs_dat_i),
		.cam_vsync_i  (cam_vsync_i),
		.cam_bank_i   (cam_bank),
		.flush_busy_i (flush_busy),
		.wbs_ack_o    (wbs_ack_o),
		.wbs_dat_o    (wbs_dat_o),
		.flush_mode_o (flush_mode)
	);

	// --------------------------------------------------
	// Camera path into the frame buffer
	// --------------------------------------------------
	cam_word_packer #(.BANK_WORDS(BANK_WORDS)) i_packer (
		.WBs_CLK_i   (WBs_CLK_i),
		.WBs_RST_i   (WBs_RST_i),
		.cam_vsync_i (cam_vsync_i),
		.cam_href_i  (cam_href_i),
		.cam_dat_i   (cam_dat_i),
		.wr_en_o     (wr_en),
		.wr_addr_o   (wr_addr),
		.wr_data_o   (wr_data),
		.cam_bank_o  (cam_bank)
	);

	fb_pingpong_ram #(.BANK_WORDS(BANK_WORDS)) i_ram (
		.WBs_CLK_i (WBs_CLK_i),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data),
		.rd_addr_i (rd_addr),
		.rd_data_o (rd_data)
	);

	// --------------------------------------------------
	// Drain to QSPI SRAM
	// --------------------------------------------------
	qspi_burst_writer #(
		.BANK_WORDS  (BANK_WORDS),
		.BURST_WORDS (BURST_WORDS),
		.START_ADDR  (START_ADDR)
	) i_writer (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.flush_mode_i (flush_mode),
		.cam_bank_i   (cam_bank),
		.rd_data_i    (rd_data),
		.rd_addr_o    (rd_addr),
		.flush_busy_o (flush_busy),
		.qspi_ncs_o   (qspi_ncs_o),
		.qspi_dat_o   (qspi_dat_o)
	);

endmodule

//--- sim/qspi_frame_monitor.sv
`timescale 1ns/1ps

module qspi_frame_monitor #(
	parameter int BURST_WORDS = 4,  // Words per frame
	parameter int MAX_FRAMES  = 8   // Frames kept for checking
) (
	input  logic                   clk_i,       // Sampled on rising edge
	input  logic                   ncs_i,       // SRAM select, active low
	input  fb_bridge_pkg::nibble_t dat_i,       // SRAM lanes
	output int                     frame_cnt_o  // Completed frames
);

	import fb_bridge_pkg::*;

	localparam int HDR = CMD_BITS + ADDR_NIBBLES; // Symbols before data

	logic [7:0] cmd_mem  [MAX_FRAMES];             // Command per frame
	qspi_addr_t addr_mem [MAX_FRAMES];             // Address per frame
	int         len_mem  [MAX_FRAMES];             // Symbols per frame
	word_t      data_mem [MAX_FRAMES*BURST_WORDS]; // Data words, all frames in order
	int         lane_err;                          // Command lanes 3:1 not zero
	int         quiet_err;                         // Lanes not zero while deselected
	int         gap_err;                           // Frame started after < 2 idle cycles

	int         sym;     // Symbol within current frame
	int         gap;     // Cycles with ncs high
	int         words;   // Words stored so far
	logic [7:0] cmd_sr;
	qspi_addr_t addr_sr;
	word_t      data_sr;

	initial begin
		frame_cnt_o = 0;
		lane_err    = 0;
		quiet_err   = 0;
		gap_err     = 0;
		sym         = 0;
		gap         = 2; // No gap rule before the first frame
		words       = 0;
	end

	// --------------------------------------------------
	// Frame decode, one symbol per cycle with ncs low
	// --------------------------------------------------
	always @(posedge clk_i) begin
		if (ncs_i === 1'b0) begin
			if (sym == 0 && gap < 2) gap_err++;
			if (sym < CMD_BITS) begin
				cmd_sr = {cmd_sr[6:0], dat_i[0]}; // Serial command on lane 0
				if (dat_i[3:1] !== 3'b000) lane_err++;
			end else if (sym < HDR) begin
				addr_sr = {addr_sr[19:0], dat_i}; // MS nibble first
			end else begin
				data_sr = {data_sr[27:0], dat_i};
				if ((sym - HDR) % WORD_NIBBLES == WORD_NIBBLES - 1 &&
						words < MAX_FRAMES*BURST_WORDS) begin
					data_mem[words] = data_sr; // Word complete
					words++;
				end
			end
			sym++;
			gap = 0;
		end else if (ncs_i === 1'b1) begin
			if (sym > 0 && frame_cnt_o < MAX_FRAMES) begin
				cmd_mem[frame_cnt_o]  = cmd_sr; // Frame just closed
				addr_mem[frame_cnt_o] = addr_sr;
				len_mem[frame_cnt_o]  = sym;
				frame_cnt_o++;
			end
			sym = 0;
			gap++;
			if (dat_i !== 4'h0) quiet_err++;
		end
	end

endmodule

//--- sim/tb_cam_qspi_bridge.sv
`timescale 1ns/1ps

module tb_cam_qspi_bridge;

	import fb_bridge_pkg::*;

	localparam int         BANK_WORDS  = 8;
	localparam int         BURST_WORDS = 4;
	localparam qspi_addr_t START_ADDR  = 24'h000004;
	localparam int         FRAME_LEN   = CMD_BITS + ADDR_NIBBLES + WORD_NIBBLES * BURST_WORDS;
	localparam int         NROWS       = 19;

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_VSYNC, OP_CAM, OP_IDLE, OP_FRAMES} op_t;
	typedef struct packed {
		op_t   op;
		word_t data; // Write word, address, byte count or frame count
		word_t exp;  // Read value, or 1 to record camera words
	} row_t;

	logic    WBs_CLK_i;
	logic    WBs_RST_i;
	logic    wbs_cyc_i;
	logic    wbs_stb_i;
	logic    wbs_we_i;
	logic    wbs_adr_i;
	word_t   wbs_dat_i;
	word_t   wbs_dat_o;
	logic    wbs_ack_o;
	logic    cam_vsync_i;
	logic    cam_href_i;
	pixel_t  cam_dat_i;
	logic    qspi_ncs_o;
	nibble_t qspi_dat_o;
	int      frame_cnt; // Frames closed by the monitor

	row_t  rows [NROWS]; // Stimulus table
	word_t exp_q [$];    // Camera words expected on the SRAM side
	int    errors  = 0;
	int    checks  = 0;
	int    checked = 0;  // Frames already compared
	int    cycles  = 0;
	int    limit   = 0;

	cam_qspi_bridge_top #(.BANK_WORDS(BANK_WORDS), .BURST_WORDS(BURST_WORDS),
		.START_ADDR(START_ADDR)) i_dut (.*);

	qspi_frame_monitor #(.BURST_WORDS(BURST_WORDS), .MAX_FRAMES(8)) i_mon (
		.clk_i       (WBs_CLK_i),
		.ncs_i       (qspi_ncs_o),
		.dat_i       (qspi_dat_o),
		.frame_cnt_o (frame_cnt)
	);

	initial begin
		WBs_CLK_i = 1'b0;
		forever #5 WBs_CLK_i = ~WBs_CLK_i; // 100 MHz
	end

	// Run length guard
	always @(posedge WBs_CLK_i) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout after %0d cycles with the table unfinished", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// Single access, ack expected exactly one cycle after the strobe
	task automatic wb_access(
		input  logic  we,
		input  logic  adr,
		input  word_t wdat,
		output word_t rdat
	);
		@(negedge WBs_CLK_i);
		wbs_cyc_i = 1'b1;
		wbs_stb_i = 1'b1;
		wbs_we_i  = we;
		wbs_adr_i = adr;
		wbs_dat_i = wdat;
		@(negedge WBs_CLK_i);
		check_value("wbs_ack_o", 32'(wbs_ack_o), 32'h1);
		rdat      = wbs_dat_o;
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i  = 1'b0;
		@(negedge WBs_CLK_i);
		check_value("wbs_ack_o", 32'(wbs_ack_o), 32'h0); // One cycle only
	endtask

	// Random bytes, at most one idle HREF cycle between two
	task automatic send_bytes(input int n, input bit record);
		int     sent;
		bit     gap_prev;
		pixel_t b;
		word_t  w;
		sent     = 0;
		gap_prev = 1'b0;
		w        = '0;
		while (sent < n) begin
			@(negedge WBs_CLK_i);
			if (!gap_prev && ($urandom % 4 == 0)) begin
				cam_href_i = 1'b0;
				gap_prev   = 1'b1;
			end else begin
				b          = pixel_t'($urandom);
				cam_href_i = 1'b1;
				cam_dat_i  = b;
				w          = {w[23:0], b}; // First byte ends up in 31:24
				sent++;
				if (sent % 4 == 0 && record) exp_q.push_back(w);
				gap_prev = 1'b0;
			end
		end
		@(negedge WBs_CLK_i);
		cam_href_i = 1'b0;
		repeat (3) @(negedge WBs_CLK_i); // Let the bank bit and writer settle
	endtask

	task automatic wait_idle();
		word_t stat;
		wb_access(1'b0, REG_STATUS, '0, stat);
		while (stat[STAT_BUSY_BIT]) begin
			wb_access(1'b0, REG_STATUS, '0, stat);
		end
	endtask

	task automatic check_frames(input int n);
		int    idx;
		word_t exp_addr;
		check_value("qspi frame count", 32'(frame_cnt), 32'(n));
		for (int k = checked; k < n && k < frame_cnt; k++) begin
			exp_addr = 32'(qspi_addr_t'(START_ADDR + k * BURST_WORDS * 4)); // 24-bit wrap
			check_value("qspi_dat_o command", 32'(i_mon.cmd_mem[k]), 32'(QSPI_CMD_WRITE));
			check_value("qspi_dat_o address", 32'(i_mon.addr_mem[k]), exp_addr);
			check_value("qspi_ncs_o frame length", 32'(i_mon.len_mem[k]), 32'(FRAME_LEN));
			for (int w = 0; w < BURST_WORDS; w++) begin
				idx = k * BURST_WORDS + w;
				if (idx < exp_q.size()) begin
					check_value("qspi_dat_o data", i_mon.data_mem[idx], exp_q[idx]);
				end else begin
					errors++;
					$display("Frame %0d carries word %0d that the camera never sent", k, w);
				end
			end
		end
		checked = n;
		check_value("qspi_dat_o command lanes", 32'(i_mon.lane_err), 32'h0);
		check_value("qspi_dat_o while deselected", 32'(i_mon.quiet_err), 32'h0);
		check_value("qspi_ncs_o gap", 32'(i_mon.gap_err), 32'h0);
	endtask

	task automatic load_table();
		rows[0]  = '{OP_RD,     32'h1,        32'h0};        // Status out of reset
		rows[1]  = '{OP_VSYNC,  32'h1,        32'h0};
		rows[2]  = '{OP_RD,     32'h1,        32'h100};      // VSYNC follows the pin
		rows[3]  = '{OP_WR,     32'h12345671, 32'h0};        // Mode 01, not flush
		rows[4]  = '{OP_RD,     32'h0,        32'h12345671};
		rows[5]  = '{OP_CAM,    32'd32,       32'h0};        // Fill bank 0
		rows[6]  = '{OP_RD,     32'h1,        32'h101};      // Bank 1, not busy
		rows[7]  = '{OP_FRAMES, 32'd0,        32'h0};        // Nothing drained
		rows[8]  = '{OP_CAM,    32'd32,       32'h0};        // Fill bank 1
		rows[9]  = '{OP_RD,     32'h1,        32'h100};
		rows[10] = '{OP_WR,     32'h12345672, 32'h0};        // Mode flush
		rows[11] = '{OP_CAM,    32'd32,       32'h1};
		rows[12] = '{OP_IDLE,   32'h0,        32'h0};
		rows[13] = '{OP_FRAMES, 32'd2,        32'h0};        // Bank 0 only
		rows[14] = '{OP_RD,     32'h1,        32'h101};      // Bank 1 held back
		rows[15] = '{OP_CAM,    32'd32,       32'h1};
		rows[16] = '{OP_IDLE,   32'h0,        32'h0};
		rows[17] = '{OP_FRAMES, 32'd4,        32'h0};
		rows[18] = '{OP_RD,     32'h1,        32'h100};
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		word_t rdat;
		int    bytes;
		int    bursts;
		void'($urandom(14182));
		WBs_RST_i   = 1'b1;
		wbs_cyc_i   = 1'b0;
		wbs_stb_i   = 1'b0;
		wbs_we_i    = 1'b0;
		wbs_adr_i   = 1'b0;
		wbs_dat_i   = '0;
		cam_vsync_i = 1'b0;
		cam_href_i  = 1'b0;
		cam_dat_i   = '0;
		load_table();
		bytes  = 0;
		bursts = 0;
		foreach (rows[i]) begin
			if (rows[i].op == OP_CAM) bytes += int'(rows[i].data);
			if (rows[i].op == OP_FRAMES && int'(rows[i].data) > bursts) begin
				bursts = int'(rows[i].data);
			end
		end
		limit = bytes + 2 * bursts * FRAME_LEN + 200;
		repeat (10) @(negedge WBs_CLK_i);
		WBs_RST_i = 1'b0;
		check_value("wbs_ack_o", 32'(wbs_ack_o), 32'h0);
		check_value("qspi_ncs_o", 32'(qspi_ncs_o), 32'h1);
		foreach (rows[i]) begin
			case (rows[i].op)
				OP_WR:     wb_access(1'b1, REG_CTRL, rows[i].data, rdat);
				OP_RD: begin
					wb_access(1'b0, rows[i].data[0], '0, rdat);
					check_value("wbs_dat_o", rdat, rows[i].exp);
				end
				OP_VSYNC: begin
					@(negedge WBs_CLK_i);
					cam_vsync_i = rows[i].data[0];
				end
				OP_CAM:    send_bytes(int'(rows[i].data), rows[i].exp[0]);
				OP_IDLE:   wait_idle();
				OP_FRAMES: check_frames(int'(rows[i].data));
				default: begin
					errors++;
					$display("Unknown operation in table row %0d", i);
				end
			endcase
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
rtl/fb_bridge_pkg.sv
rtl/wb_ctrl_regs.sv
rtl/cam_word_packer.sv
rtl/fb_pingpong_ram.sv
rtl/qspi_burst_writer.sv
rtl/cam_qspi_bridge_top.sv
sim/qspi_frame_monitor.sv
sim/tb_cam_qspi_bridge.sv

//--- Makefile
TOP := tb_cam_qspi_bridge

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module cam_qspi_bridge_top
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

# Pass only when the run prints the pass line
sim:
	verilator --binary --timing -Wno-fatal -j 0 -Mdir obj_dir -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
